// File: sim.f
source/tpu_pkg.sv
source/skew_line.sv
source/a_feeder.sv
source/weight_loader.sv
source/pe_array.sv
source/result_drain.sv
source/tpu_ctrl.sv
source/tpu_top.sv
dv/tpu_chk.sv
dv/tpu_tb.sv

// File: Bender.yml
package:
  name: tpu_systolic

sources:
  - source/tpu_pkg.sv
  - source/skew_line.sv
  - source/a_feeder.sv
  - source/weight_loader.sv
  - source/pe_array.sv
  - source/result_drain.sv
  - source/tpu_ctrl.sv
  - source/tpu_top.sv
  - target: simulation
    files:
      - dv/tpu_chk.sv
      - dv/tpu_tb.sv

// File: dv/tpu_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the 5x5 systolic multiplier with A, B and C memory models
// Runs identity, random, back-to-back and reset-during-run jobs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tpu_tb import tpu_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int NUM_JOBS     = 13;
	localparam int JOB_MARGIN   = 10;
	localparam int JOB_CYCLES   = LOAD_STEPS + FIRST_ROW_LAT + ARRAY_DIM + JOB_MARGIN;
	localparam int WDOG_CYCLES  = NUM_JOBS * JOB_CYCLES + 20;  // Plus reset and gaps

	logic  clk;
	logic  rst;
	logic  start_i;
	dim_t  m_i;
	dim_t  n_i;
	dim_t  k_i;
	word_t data_a_i;
	word_t data_b_i;
	dim_t  index_a_o;
	dim_t  index_b_o;
	dim_t  index_o_o;
	logic  wr_en_o;
	word_t data_o_o;
	logic  done_o;

	word_t a_mem [ARRAY_DIM];  // Word r is column r of A
	word_t b_mem [ARRAY_DIM];  // Word r is row r of B
	word_t c_mem [ARRAY_DIM];

	integer seed;
	int     value_errors;
	int     other_errors;
	int     wr_cnt;
	dim_t   last_wr_idx;
	dim_t   job_m;
	dim_t   job_n;
	dim_t   job_k;
	string  job_name;
	event   check_ev;

	tpu_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.start_i   (start_i),
		.m_i       (m_i),
		.n_i       (n_i),
		.k_i       (k_i),
		.data_a_i  (data_a_i),
		.data_b_i  (data_b_i),
		.index_a_o (index_a_o),
		.index_b_o (index_b_o),
		.index_o_o (index_o_o),
		.wr_en_o   (wr_en_o),
		.data_o_o  (data_o_o),
		.done_o    (done_o)
	);

	// Combinational memory reads
	assign data_a_i = a_mem[index_a_o];
	assign data_b_i = b_mem[index_b_o];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// C[t][c] is the sum over r < k of A[t][r] * B[r][c], kept to 8 bits
	function automatic word_t ref_matmul(input int t, input dim_t n, input dim_t k);
		word_t       row;
		logic [15:0] prod;
		lane_t       acc;
		for (int c = 0; c < ARRAY_DIM; c++) begin
			acc = '0;
			for (int r = 0; r < ARRAY_DIM; r++) begin
				if (r < k && c < n) begin
					prod = a_mem[r][t] * b_mem[r][c];  // a_mem[r][t] is A[t][r]
					acc  = acc + prod[7:0];
				end
			end
			row[c] = acc;
		end
		return row;
	endfunction

	function automatic word_t fill_word(input int row);
		word_t w;
		for (int j = 0; j < ARRAY_DIM; j++) w[j] = lane_t'(8'hc3 ^ (row * 16 + j));
		return w;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			value_errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_dim(input string name, input dim_t exp, input dim_t act);
		if (act !== exp) begin
			value_errors++;
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Result memory and write counting
	always @(posedge clk) begin
		if (!rst && wr_en_o) begin
			if (index_o_o >= job_m) begin
				other_errors++;
				$display("%s: write to row %0d, outside rows 0 to %0d", job_name,
					index_o_o, job_m - 1);
			end
			if (index_o_o < ARRAY_DIM) begin
				c_mem[index_o_o] = data_o_o;  // Rows past m land here too
			end
			wr_cnt++;
			last_wr_idx = index_o_o;
		end
	end

	// Compares one finished job against the reference
	initial begin
		forever begin
			@(check_ev);
			if (wr_cnt != job_m) begin
				other_errors++;
				$display("%s: expected %0d writes but saw %0d", job_name, job_m, wr_cnt);
			end
			if (wr_cnt > 0) begin
				check_dim({job_name, " last index"}, dim_t'(job_m - 1), last_wr_idx);
			end
			for (int t = 0; t < ARRAY_DIM; t++) begin
				if (t < job_m) begin
					check_word($sformatf("%s row %0d", job_name, t),
						ref_matmul(t, job_n, job_k), c_mem[t]);
				end else begin
					check_word($sformatf("%s unwritten row %0d", job_name, t),
						fill_word(t), c_mem[t]);
				end
			end
		end
	end

	task automatic fill_random(input dim_t k);
		for (int r = 0; r < ARRAY_DIM; r++) begin
			for (int c = 0; c < ARRAY_DIM; c++) begin
				a_mem[r][c] = lane_t'($random(seed));
				b_mem[r][c] = lane_t'($random(seed));
				if (r >= k) b_mem[r][c] = b_mem[r][c] | 8'h01;  // Stale, never zero
			end
		end
	endtask

	task automatic start_job(input string name, input dim_t m, input dim_t n, input dim_t k);
		job_name = name;
		job_m    = m;
		job_n    = n;
		job_k    = k;
		wr_cnt   = 0;
		for (int i = 0; i < ARRAY_DIM; i++) c_mem[i] = fill_word(i);
		@(posedge clk);
		start_i <= 1'b1;
		m_i     <= m;
		n_i     <= n;
		k_i     <= k;
		@(posedge clk);
		start_i <= 1'b0;
	endtask

	task automatic run_job(input string name, input dim_t m, input dim_t n, input dim_t k);
		int cycles;
		start_job(name, m, n, k);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!done_o && cycles < JOB_CYCLES);
		if (!done_o) begin
			other_errors++;
			$display("%s: done_o did not rise within %0d cycles", name, JOB_CYCLES);
		end else begin
			-> check_ev;
		end
		@(negedge clk);
	endtask

	task automatic reset_mid_run();
		int cycles;
		start_job("reset during run", 3'd5, 3'd5, 3'd5);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!wr_en_o && cycles < JOB_CYCLES);
		if (!wr_en_o) begin
			other_errors++;
			$display("reset during run: no write seen before the reset point");
		end
		rst <= 1'b1;
		@(negedge clk);
		if (wr_en_o || done_o) begin
			other_errors++;
			$display("reset during run: wr_en_o or done_o stayed high under reset");
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (wr_en_o || done_o) begin
			other_errors++;
			$display("reset during run: wr_en_o or done_o high after reset release");
		end
	endtask

	// Watchdog
	initial begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, jobs did not finish", WDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		dim_t rm;
		dim_t rn;
		dim_t rk;
		seed         = 32'ha0ae_acdc;
		value_errors = 0;
		other_errors = 0;
		wr_cnt       = 0;
		job_m        = '0;
		job_name     = "reset";
		rst          = 1'b1;
		start_i      = 1'b0;
		m_i          = '0;
		n_i          = '0;
		k_i          = '0;
		fill_random(3'd5);
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		for (int r = 0; r < ARRAY_DIM; r++) begin
			for (int c = 0; c < ARRAY_DIM; c++) b_mem[r][c] = (r == c) ? 8'd1 : 8'd0;
		end
		run_job("identity", 3'd5, 3'd5, 3'd5);

		for (int i = 0; i < 3; i++) begin
			fill_random(3'd5);
			run_job($sformatf("full tile %0d", i), 3'd5, 3'd5, 3'd5);
		end

		for (int i = 0; i < 5; i++) begin
			rm = dim_t'(1 + ({$random(seed)} % ARRAY_DIM));
			rn = dim_t'(1 + ({$random(seed)} % ARRAY_DIM));
			rk = dim_t'(1 + ({$random(seed)} % ARRAY_DIM));
			fill_random(rk);
			run_job($sformatf("small dims %0d", i), rm, rn, rk);
		end

		// Second job follows done without a reset
		fill_random(3'd5);
		run_job("back to back first", 3'd5, 3'd5, 3'd5);
		fill_random(3'd2);
		run_job("back to back second", 3'd3, 3'd4, 3'd2);

		fill_random(3'd5);
		reset_mid_run();
		fill_random(3'd4);
		run_job("after reset", 3'd4, 3'd5, 3'd4);

		$display("Checks done: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors + other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tpu_chk.sv
////////////////////////////////////////////////////////////////////////////
// Control output assertions, bound into every tpu_top instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tpu_chk import tpu_pkg::*; (
	input wire  clk,
	input wire  rst,
	input wire  start_i,
	input dim_t m_i,
	input wire  wr_en_o,
	input dim_t index_o_o,
	input wire  done_o
);

	// No writes once the job is finished
	a_no_write_in_done: assert property (@(posedge clk) disable iff (rst)
		!(wr_en_o && done_o))
		else $error("wr_en_o high while done_o is high");

	a_index_in_range: assert property (@(posedge clk) disable iff (rst)
		wr_en_o |-> (index_o_o < m_i))
		else $error("result write index %0d not below m %0d", index_o_o, m_i);

	// Done level only falls after a start
	a_done_held: assert property (@(posedge clk) disable iff (rst)
		(done_o && !start_i) |=> done_o)
		else $error("done_o fell without a start");

endmodule

bind tpu_top tpu_chk i_chk (
	.clk       (clk),
	.rst       (rst),
	.start_i   (start_i),
	.m_i       (m_i),
	.wr_en_o   (wr_en_o),
	.index_o_o (index_o_o),
	.done_o    (done_o)
);

`default_nettype wire

// File: source/tpu_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the 5x5 systolic matrix multiplier, C = A * B for one tile
// Reads A columns and B rows combinationally, writes C rows on wr_en_o
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tpu_top import tpu_pkg::*; (
	input  wire   clk,
	input  wire   rst,
	input  wire   start_i,
	input  dim_t  m_i,
	input  dim_t  n_i,
	input  dim_t  k_i,
	input  word_t data_a_i,
	input  word_t data_b_i,
	output dim_t  index_a_o,
	output dim_t  index_b_o,
	output dim_t  index_o_o,
	output logic  wr_en_o,
	output word_t data_o_o,
	output logic  done_o
);

	logic                                  load;
	dim_t                                  load_idx;
	logic                                  run_start;
	logic                                  drain_done;
	lane_t [ARRAY_DIM-1:0]                 a_stream;
	lane_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0]  weights;
	lane_t [ARRAY_DIM-1:0]                 bottom;

	tpu_ctrl i_ctrl (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.drain_done_i (drain_done),
		.load_o       (load),
		.load_idx_o   (load_idx),
		.run_start_o  (run_start),
		.done_o       (done_o)
	);

	// Word r of A and of B are read in the same load step
	assign index_a_o = load_idx;
	assign index_b_o = load_idx;

	a_feeder i_a_feeder (
		.clk         (clk),
		.rst         (rst),
		.load_i      (load),
		.load_idx_i  (load_idx),
		.data_a_i    (data_a_i),
		.run_start_i (run_start),
		.a_stream_o  (a_stream)
	);

	weight_loader i_weight_loader (
		.clk        (clk),
		.rst        (rst),
		.load_i     (load),
		.load_idx_i (load_idx),
		.data_b_i   (data_b_i),
		.n_i        (n_i),
		.k_i        (k_i),
		.weights_o  (weights)
	);

	pe_array i_pe_array (
		.clk        (clk),
		.rst        (rst),
		.a_stream_i (a_stream),
		.weights_i  (weights),
		.bottom_o   (bottom)
	);

	result_drain i_result_drain (
		.clk          (clk),
		.rst          (rst),
		.run_start_i  (run_start),
		.bottom_i     (bottom),
		.m_i          (m_i),
		.wr_en_o      (wr_en_o),
		.index_o_o    (index_o_o),
		.data_o_o     (data_o_o),
		.drain_done_o (drain_done)
	);

endmodule

`default_nettype wire

// File: source/tpu_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Job sequencing FSM: idle, load of five words, run until drained, done
// Owns the load step counter and the done level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tpu_ctrl import tpu_pkg::*; (
	input  wire  clk,
	input  wire  rst,
	input  wire  start_i,
	input  wire  drain_done_i,
	output logic load_o,
	output dim_t load_idx_o,
	output logic run_start_o,
	output logic done_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_RUN,
		ST_DONE
	} state_t;

	state_t state_q;
	dim_t   load_idx_q;
	logic   run_start_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q     <= ST_IDLE;
			load_idx_q  <= '0;
			run_start_q <= 1'b0;
		end else begin
			run_start_q <= 1'b0;
			case (state_q)
				ST_IDLE, ST_DONE: begin
					// Done level falls with the next start
					if (start_i) begin
						state_q    <= ST_LOAD;
						load_idx_q <= '0;
					end
				end
				ST_LOAD: begin
					if (load_idx_q == dim_t'(LOAD_STEPS - 1)) begin
						state_q     <= ST_RUN;
						run_start_q <= 1'b1;  // First run cycle
						load_idx_q  <= '0;
					end else begin
						load_idx_q <= load_idx_q + 1'b1;
					end
				end
				ST_RUN: begin
					if (drain_done_i) state_q <= ST_DONE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	assign load_o      = (state_q == ST_LOAD);
	assign load_idx_o  = load_idx_q;  // Same index for A and B memories
	assign run_start_o = run_start_q;
	assign done_o      = (state_q == ST_DONE);

endmodule

`default_nettype wire

// File: source/result_drain.sv
////////////////////////////////////////////////////////////////////////////
// Lines up the bottom partial sums into whole rows and writes rows 0..m-1
// Pulses drain_done_o in the cycle after the last write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module result_drain import tpu_pkg::*; (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     run_start_i,
	input  lane_t [ARRAY_DIM-1:0]   bottom_i,
	input  dim_t                    m_i,
	output logic                    wr_en_o,
	output dim_t                    index_o_o,
	output word_t                   data_o_o,
	output logic                    drain_done_o
);

	localparam int LAT_W = $clog2(FIRST_ROW_LAT + 1);

	logic [LAT_W-1:0] lat_cnt_q;  // Cycles left until row 0
	logic             wait_q;
	logic             write_q;
	logic             done_q;
	dim_t             idx_q;

	// Column c leaves the array c cycles late
	for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
		skew_line #(
			.payload_t (lane_t),
			.DEPTH     (ARRAY_DIM - 1 - c)
		) i_deskew (
			.clk (clk),
			.rst (rst),
			.d_i (bottom_i[c]),
			.q_o (data_o_o[c])
		);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wait_q    <= 1'b0;
			write_q   <= 1'b0;
			done_q    <= 1'b0;
			lat_cnt_q <= '0;
			idx_q     <= '0;
		end else begin
			done_q <= 1'b0;
			if (run_start_i) begin
				wait_q    <= 1'b1;
				write_q   <= 1'b0;
				lat_cnt_q <= LAT_W'(FIRST_ROW_LAT - 1);
				idx_q     <= '0;
			end else if (wait_q) begin
				if (lat_cnt_q == LAT_W'(1)) begin
					wait_q  <= 1'b0;
					write_q <= 1'b1;  // Row 0 is aligned next cycle
				end
				lat_cnt_q <= lat_cnt_q - 1'b1;
			end else if (write_q) begin
				if (idx_q == m_i - dim_t'(1)) begin
					write_q <= 1'b0;
					done_q  <= 1'b1;
				end else begin
					idx_q <= idx_q + 1'b1;
				end
			end
		end
	end

	assign wr_en_o      = write_q;
	assign index_o_o    = idx_q;
	assign drain_done_o = done_q;

endmodule

`default_nettype wire

// File: source/pe_array.sv
////////////////////////////////////////////////////////////////////////////
// Weight-stationary 5x5 grid of multiply-accumulate cells
// A moves right one cell per cycle, partial sums move down one row per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pe_array import tpu_pkg::*; (
	input  wire                                    clk,
	input  wire                                    rst,
	input  lane_t [ARRAY_DIM-1:0]                  a_stream_i,
	input  lane_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0]   weights_i,
	output lane_t [ARRAY_DIM-1:0]                  bottom_o
);

	// Rightmost column has no neighbour to pass A to
	lane_t a_q    [ARRAY_DIM][ARRAY_DIM-1];
	lane_t psum_q [ARRAY_DIM][ARRAY_DIM];

	// Cell inputs
	lane_t a_in   [ARRAY_DIM][ARRAY_DIM];
	lane_t sum_in [ARRAY_DIM][ARRAY_DIM];

	for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
		for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
			if (c == 0) begin : g_left
				assign a_in[r][c] = a_stream_i[r];
			end else begin : g_inner
				assign a_in[r][c] = a_q[r][c-1];
			end

			if (r == 0) begin : g_top
				assign sum_in[r][c] = '0;  // Top row starts from nothing
			end else begin : g_below
				assign sum_in[r][c] = psum_q[r-1][c];
			end
		end
	end

	// Products and sums keep the low 8 bits
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int r = 0; r < ARRAY_DIM; r++) begin
				for (int c = 0; c < ARRAY_DIM; c++) psum_q[r][c] <= '0;
				for (int c = 0; c < ARRAY_DIM - 1; c++) a_q[r][c] <= '0;
			end
		end else begin
			for (int r = 0; r < ARRAY_DIM; r++) begin
				for (int c = 0; c < ARRAY_DIM; c++) begin
					psum_q[r][c] <= sum_in[r][c] + a_in[r][c] * weights_i[r][c];
				end
				for (int c = 0; c < ARRAY_DIM - 1; c++) begin
					a_q[r][c] <= a_in[r][c];
				end
			end
		end
	end

	for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_out
		assign bottom_o[c] = psum_q[ARRAY_DIM-1][c];
	end

endmodule

`default_nettype wire

// File: source/weight_loader.sv
////////////////////////////////////////////////////////////////////////////
// Stationary weight grid, one B row captured per load step
// Rows at or past k and lanes at or past n are stored as zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module weight_loader import tpu_pkg::*; (
	input  wire                                    clk,
	input  wire                                    rst,
	input  wire                                    load_i,
	input  dim_t                                   load_idx_i,
	input  word_t                                  data_b_i,
	input  dim_t                                   n_i,
	input  dim_t                                   k_i,
	output lane_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0]   weights_o  // [row][col]
);

	// Weights hold between loads
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			weights_o <= '0;
		end else if (load_i) begin
			for (int c = 0; c < ARRAY_DIM; c++) begin
				if (load_idx_i >= k_i || dim_t'(c) >= n_i) begin
					weights_o[load_idx_i][c] <= '0;  // Outside the k x n block
				end else begin
					weights_o[load_idx_i][c] <= data_b_i[c];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/a_feeder.sv
////////////////////////////////////////////////////////////////////////////
// Holds the A columns from the load phase and feeds them into the array
// Row r gets one element per run cycle, delayed by r cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module a_feeder import tpu_pkg::*; (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     load_i,
	input  dim_t                    load_idx_i,
	input  word_t                   data_a_i,
	input  wire                     run_start_i,
	output lane_t [ARRAY_DIM-1:0]   a_stream_o
);

	word_t cols_q [ARRAY_DIM];  // Column r of A, lane t is A[t][r]
	logic  feed_q;              // Streaming after the first run cycle
	logic  feeding;

	// Zero on the rows while loading or idle
	assign feeding = run_start_i | feed_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			feed_q <= 1'b0;
		end else if (load_i) begin
			feed_q <= 1'b0;
		end else if (run_start_i) begin
			feed_q <= 1'b1;
		end
	end

	// Top lane goes out, zeros shift in from the bottom
	always_ff @(posedge clk) begin
		if (load_i) begin
			cols_q[load_idx_i] <= data_a_i;
		end else if (feeding) begin
			for (int r = 0; r < ARRAY_DIM; r++) begin
				cols_q[r] <= {cols_q[r][1:ARRAY_DIM-1], lane_t'(0)};
			end
		end
	end

	for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
		lane_t feed;

		assign feed = feeding ? cols_q[r][0] : '0;

		skew_line #(
			.payload_t (lane_t),
			.DEPTH     (r)
		) i_skew (
			.clk (clk),
			.rst (rst),
			.d_i (feed),
			.q_o (a_stream_o[r])
		);
	end

endmodule

`default_nettype wire

// File: source/skew_line.sv
////////////////////////////////////////////////////////////////////////////
// Register delay line of any payload type, zero after reset
// Skews A into the array and lines up the bottom partial sums
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module skew_line #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 1
) (
	input  wire      clk,
	input  wire      rst,
	input  payload_t d_i,
	output payload_t q_o
);

	if (DEPTH == 0) begin : g_pass
		assign q_o = d_i;  // No delay needed on this lane
	end else begin : g_chain
		payload_t stage_q [DEPTH];

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				for (int i = 0; i < DEPTH; i++) stage_q[i] <= '0;
			end else begin
				stage_q[0] <= d_i;
				for (int i = 1; i < DEPTH; i++) stage_q[i] <= stage_q[i-1];
			end
		end

		assign q_o = stage_q[DEPTH-1];
	end

endmodule

`default_nettype wire

// File: source/tpu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared sizes, lane and word types and latency constants for the 5x5 TPU
// Imported by every RTL block of the systolic multiplier
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package tpu_pkg;

	// Array geometry
	localparam int ARRAY_DIM = 5;  // Edge length of the PE grid
	localparam int LANE_W    = 8;  // One operand or partial sum
	localparam int DIM_W     = 3;  // Enough for 0..7

	// One 8-bit value, used for A elements, weights and partial sums
	typedef logic [LANE_W-1:0] lane_t;

	// Memory word and output row, lane 0 sits in the top byte
	typedef lane_t [0:ARRAY_DIM-1] word_t;

	// Matrix dimension or word index
	typedef logic [DIM_W-1:0] dim_t;

	// One memory word of A and B per load cycle
	localparam int LOAD_STEPS = ARRAY_DIM;

	// Run cycle 0 to aligned output row 0 at the drain
	// The feeder presents A[0][r] combinationally from its column register,
	// so row r sees it in run cycle r. Column c of row r registers it in
	// cycle r + c, the bottom partial sum C[0][c] is visible in cycle c + 5
	// and the de-skew line of depth 4 - c lines every column up at cycle 9.
	localparam int FIRST_ROW_LAT = ARRAY_DIM + (ARRAY_DIM - 1);

endpackage

`default_nettype wire
